//--- build.f
hw/io_bus_pkg.sv
hw/io_map_pkg.sv
hw/io_host_port.sv
hw/io_bridge.sv
hw/io_ctrl_regs.sv
hw/io_random.sv
hw/io_tick_timer.sv
hw/io_subsys_top.sv
tests/io_subsys_asserts.sv
tests/tb_io_subsys.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_io_subsys \
	-f build.f -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| echo "build or simulation returned an error"
grep -q "Verification passed" sim.log 2>/dev/null \
	&& echo "simulation PASS" \
	|| { echo "simulation FAIL, see sim.log"; exit 1; }

//--- tests/tb_io_subsys.sv
`timescale 1ns/1ps
`default_nettype none

// directed testbench for the bridged i/o region
module tb_io_subsys;

	logic                                 clk100;
	logic                                 rst;
	logic                                 host_req;
	io_bus_pkg::io_req_t                  host_bus;
	logic                                 host_ack;
	io_bus_pkg::io_resp_t                 host_resp;
	logic [io_map_pkg::LED_W-1:0]         led;
	logic [io_map_pkg::NODE_RST_W-1:0]    node_rst;
	logic                                 tmr_irq;

	logic [31:0] rnd_state;	// xorshift state
	int unsigned cyc;	// free clock count
	int unsigned ack_cyc;	// cyc at the last observed ack

	io_subsys_top i_io_subsys_top (
		.clk100(clk100), .rst(rst),
		.host_req_i(host_req), .host_bus_i(host_bus),
		.host_ack_o(host_ack), .host_resp_o(host_resp),
		.led_o(led), .node_rst_o(node_rst), .tmr_irq_o(tmr_irq)
	);

	bind io_subsys_top io_subsys_asserts i_io_subsys_asserts (
		.clk100(clk100), .rst(rst), .host_req_i(host_req_i), .host_ack_i(host_ack_o),
		.rstctl_stb_i(rstctl_stb), .preq_i(preq),
		.node_rst_i(node_rst_o), .tmr_irq_i(tmr_irq_o)
	);

	initial clk100 = 1'b0;
	always #20 clk100 = ~clk100;	// 40 ns period

	initial cyc = 0;
	always @(posedge clk100) cyc <= cyc + 1;

	// ----------------------------------------
	// reporting
	// ----------------------------------------
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1, "run aborted");
	endtask

	task automatic check(input string test, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("error %s expected %h actual %h", test, exp, act);
			$display("Verification failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// ----------------------------------------
	// stimulus and reference models
	// ----------------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rnd_state = xorshift(rnd_state);
		return rnd_state;
	endfunction

	// galois step, shift right and fold taps on a dropped 1
	function automatic logic [31:0] lfsr_model(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? io_map_pkg::RAND_TAPS : 32'd0);
	endfunction

	// one full four-phase cycle
	task automatic handshake(input io_bus_pkg::io_cmd_e cmd, input logic [31:0] adr,
			input logic [3:0] sel, input logic [31:0] dat,
			output io_bus_pkg::io_resp_t resp);
		int n;
		@(posedge clk100);
		host_bus.cmd <= cmd;
		host_bus.adr <= adr;
		host_bus.sel <= sel;
		host_bus.dat <= dat;
		host_req     <= 1'b1;
		n = 0;
		while (host_ack !== 1'b1) begin
			@(posedge clk100);
			n++;
			if (n > 16) abort_run("timeout waiting for host_ack_o to rise");
		end
		resp    = host_resp;	// valid while ack is high
		ack_cyc = cyc;
		host_req <= 1'b0;
		n = 0;
		while (host_ack !== 1'b0) begin
			@(posedge clk100);
			n++;
			if (n > 16) abort_run("timeout waiting for host_ack_o to fall");
		end
	endtask

	task automatic host_write(input logic [31:0] adr, input logic [3:0] sel,
			input logic [31:0] dat, output io_bus_pkg::io_resp_t resp);
		handshake(io_bus_pkg::IO_STORE, adr, sel, dat, resp);
	endtask

	task automatic host_read(input logic [31:0] adr, output io_bus_pkg::io_resp_t resp);
		handshake(io_bus_pkg::IO_LOAD, adr, 4'hf, 32'd0, resp);
	endtask

	task automatic wait_irq(input logic level, input int limit, input string msg);
		int n;
		n = 0;
		while (tmr_irq !== level) begin
			@(posedge clk100);
			n++;
			if (n > limit) abort_run(msg);
		end
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------
	task automatic test_leds();
		io_bus_pkg::io_resp_t resp;
		logic [7:0] exp_led;
		logic [31:0] r;
		int i;
		for (i = 0; i < 6; i++) begin
			r = next_rand();
			host_write({io_map_pkg::IO_PAGE_LEDS, 8'h00}, r[11:8] | 4'b0001, r, resp);
			exp_led = r[7:0];	// low lane only
			check("test_leds write err", 32'd0, 32'(resp.err));
			check("test_leds led_o", 32'(exp_led), 32'(led));
			host_read({io_map_pkg::IO_PAGE_LEDS, 8'h00}, resp);
			check("test_leds read err", 32'd0, 32'(resp.err));
			check("test_leds read data", 32'(exp_led), resp.dat);
			r = next_rand();
			host_write({io_map_pkg::IO_PAGE_LEDS, 8'h00}, r[11:8] & 4'b1110, r, resp);
			check("test_leds lane 0 off", 32'(exp_led), 32'(led));	// must hold
		end
	endtask

	task automatic read_rand_seq(input logic [31:0] start, input string test);
		io_bus_pkg::io_resp_t resp;
		logic [31:0] model;
		int i;
		model = start;
		for (i = 0; i < 5; i++) begin
			host_read({io_map_pkg::IO_PAGE_RAND, 8'h00}, resp);
			check(test, 32'd0, 32'(resp.err));
			check(test, model, resp.dat);
			model = lfsr_model(model);	// read steps the state once
		end
	endtask

	task automatic test_random();
		io_bus_pkg::io_resp_t resp;
		logic [31:0] seed;
		read_rand_seq(io_map_pkg::RAND_SEED_DEFAULT, "test_random from reset");
		seed = next_rand();
		if (seed == 32'd0)
			seed = 32'd1;
		host_write({io_map_pkg::IO_PAGE_RAND, 8'h00}, 4'hf, seed, resp);
		check("test_random seed err", 32'd0, 32'(resp.err));
		read_rand_seq(seed, "test_random from seed");
		host_write({io_map_pkg::IO_PAGE_RAND, 8'h00}, 4'hf, 32'd0, resp);	// zero seed
		read_rand_seq(io_map_pkg::RAND_SEED_DEFAULT, "test_random zero seed");
	endtask

	task automatic test_reset_pulse();
		io_bus_pkg::io_resp_t resp;
		logic [31:0] r;
		logic [15:0] vec;
		int unsigned t_ack;
		int unsigned elapsed;
		int n;
		r = next_rand();
		vec = r[15:0];
		if (vec == 16'd0)
			vec = 16'h0001;
		host_write({io_map_pkg::IO_PAGE_RSTCTL, 8'h00}, 4'b0001, {r[31:16], vec}, resp);
		t_ack = ack_cyc;
		check("test_reset_pulse write err", 32'd0, 32'(resp.err));
		check("test_reset_pulse node_rst_o", 32'(vec), 32'(node_rst));
		host_read({io_map_pkg::IO_PAGE_RSTCTL, 8'h00}, resp);
		check("test_reset_pulse read", 32'(vec), resp.dat);
		n = 0;
		while (node_rst !== '0) begin
			@(posedge clk100);
			n++;
			if (n > io_map_pkg::RST_PULSE_CYCLES + 16)
				abort_run("timeout waiting for node_rst_o to clear");
		end
		elapsed = cyc - t_ack;
		if (elapsed < io_map_pkg::RST_PULSE_CYCLES - 4 || elapsed > io_map_pkg::RST_PULSE_CYCLES)
			abort_run($sformatf("node_rst_o cleared %0d cycles after ack, out of range",
				elapsed));
	endtask

	task automatic test_unmapped();
		io_bus_pkg::io_resp_t resp;
		logic [31:0] adrs [4];
		logic [7:0] led_before;
		logic [15:0] rst_before;
		logic [31:0] r;
		int i;
		r = next_rand();
		adrs[0] = 32'h0000_0000;
		adrs[1] = {io_map_pkg::IO_PAGE_LEDS - 24'd1, 8'h00};	// page between rand and leds
		adrs[2] = {io_map_pkg::IO_PAGE_RSTCTL - 24'd1, 8'h04};
		adrs[3] = {8'h12, r[23:0]};	// never an fd page
		led_before = led;
		rst_before = node_rst;
		for (i = 0; i < 4; i++) begin
			host_read(adrs[i], resp);
			check("test_unmapped read err", 32'd1, 32'(resp.err));
			check("test_unmapped read data", 32'd0, resp.dat);
			host_write(adrs[i], 4'hf, next_rand(), resp);
			check("test_unmapped write err", 32'd1, 32'(resp.err));
			check("test_unmapped write data", 32'd0, resp.dat);
			check("test_unmapped led_o", 32'(led_before), 32'(led));
			check("test_unmapped node_rst_o", 32'(rst_before), 32'(node_rst));
		end
	endtask

	task automatic test_timer();
		int unsigned t_rise;
		int unsigned t_fall;
		int unsigned t_next;
		wait_irq(1'b0, 2 * io_map_pkg::TMR_PERIOD, "timeout waiting for tmr_irq_o low");
		wait_irq(1'b1, 2 * io_map_pkg::TMR_PERIOD, "timeout waiting for tmr_irq_o to rise");
		t_rise = cyc;
		wait_irq(1'b0, io_map_pkg::TMR_PERIOD, "timeout waiting for tmr_irq_o to fall");
		t_fall = cyc;
		wait_irq(1'b1, 2 * io_map_pkg::TMR_PERIOD, "timeout waiting for next tmr_irq_o rise");
		t_next = cyc;
		check("test_timer high time", 32'(io_map_pkg::TMR_OFF - io_map_pkg::TMR_ON),
			t_fall - t_rise);
		check("test_timer period", 32'(io_map_pkg::TMR_PERIOD), t_next - t_rise);
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		rst       = 1'b1;
		host_req  = 1'b0;
		host_bus  = '0;
		rnd_state = 32'h4df6704b;
		repeat (16) @(posedge clk100);
		rst <= 1'b0;
		@(posedge clk100);
		check("reset host_ack_o", 32'd0, 32'(host_ack));
		check("reset led_o", 32'd0, 32'(led));
		check("reset node_rst_o", 32'd0, 32'(node_rst));
		check("reset tmr_irq_o", 32'd0, 32'(tmr_irq));
		test_leds();
		test_random();
		test_reset_pulse();
		test_unmapped();
		test_timer();
		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/io_subsys_asserts.sv
`timescale 1ns/1ps
`default_nettype none

// handshake, reset pulse and timer pulse properties
module io_subsys_asserts (
	input  wire                                  clk100,
	input  wire                                  rst,
	input  wire                                  host_req_i,
	input  wire                                  host_ack_i,
	input  wire                                  rstctl_stb_i,
	input  io_bus_pkg::io_req_t                  preq_i,
	input  wire [io_map_pkg::NODE_RST_W-1:0]     node_rst_i,
	input  wire                                  tmr_irq_i
);

	logic       rst_wr;	// store hitting the reset register
	logic [7:0] nz_cnt;	// cycles vector nonzero since last write
	logic [7:0] hi_cnt;	// cycles irq high

	assign rst_wr = rstctl_stb_i && preq_i.cmd == io_bus_pkg::IO_STORE && |preq_i.sel[1:0];

	always_ff @(posedge clk100) begin
		if (rst || rst_wr)
			nz_cnt <= '0;
		else if (node_rst_i != '0 && nz_cnt != 8'hff)
			nz_cnt <= nz_cnt + 8'd1;
	end

	always_ff @(posedge clk100) begin
		if (rst || !tmr_irq_i)
			hi_cnt <= '0;
		else if (hi_cnt != 8'hff)
			hi_cnt <= hi_cnt + 8'd1;
	end

	ack_needs_req: assert property (@(posedge clk100) disable iff (rst)
		$rose(host_ack_i) |-> host_req_i)
		else $error("host_ack_o rose while host_req_i was low");

	rst_pulse_len: assert property (@(posedge clk100) disable iff (rst)
		nz_cnt <= 8'(io_map_pkg::RST_PULSE_CYCLES))
		else $error("node_rst_o held longer than the pulse time");

	irq_width: assert property (@(posedge clk100) disable iff (rst)
		$fell(tmr_irq_i) |-> hi_cnt == 8'(io_map_pkg::TMR_OFF - io_map_pkg::TMR_ON))
		else $error("tmr_irq_o pulse width wrong");

endmodule

`default_nettype wire

//--- hw/io_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

// bridged i/o region: host port -> bridge -> register blocks
module io_subsys_top (
	input  wire                                  clk100,
	input  wire                                  rst,
	input  wire                                  host_req_i,
	input  io_bus_pkg::io_req_t                  host_bus_i,
	output logic                                 host_ack_o,
	output io_bus_pkg::io_resp_t                 host_resp_o,
	output logic [io_map_pkg::LED_W-1:0]         led_o,
	output logic [io_map_pkg::NODE_RST_W-1:0]    node_rst_o,
	output logic                                 tmr_irq_o
);

	// port <-> bridge
	logic                  req_stb;
	io_bus_pkg::io_req_t   req;
	logic                  rsp_vld;
	io_bus_pkg::io_resp_t  rsp;

	// bridge <-> peripherals
	io_bus_pkg::io_req_t   preq;
	logic                  leds_stb, rand_stb, rstctl_stb;
	logic                  leds_ack, rand_ack, rstctl_ack;
	logic [31:0]           leds_dat, rand_dat, rstctl_dat;

	io_host_port i_io_host_port (
		.clk100(clk100), .rst(rst),
		.host_req_i(host_req_i), .host_bus_i(host_bus_i),
		.host_ack_o(host_ack_o), .host_resp_o(host_resp_o),
		.req_stb_o(req_stb), .req_o(req), .rsp_vld_i(rsp_vld), .rsp_i(rsp)
	);

	io_bridge i_io_bridge (
		.clk100(clk100), .rst(rst),
		.req_stb_i(req_stb), .req_i(req), .rsp_vld_o(rsp_vld), .rsp_o(rsp),
		.preq_o(preq),
		.leds_stb_o(leds_stb), .rand_stb_o(rand_stb), .rstctl_stb_o(rstctl_stb),
		.leds_ack_i(leds_ack), .rand_ack_i(rand_ack), .rstctl_ack_i(rstctl_ack),
		.leds_dat_i(leds_dat), .rand_dat_i(rand_dat), .rstctl_dat_i(rstctl_dat)
	);

	io_ctrl_regs i_io_ctrl_regs (
		.clk100(clk100), .rst(rst), .preq_i(preq),
		.leds_stb_i(leds_stb), .rstctl_stb_i(rstctl_stb),
		.leds_ack_o(leds_ack), .leds_dat_o(leds_dat),
		.rstctl_ack_o(rstctl_ack), .rstctl_dat_o(rstctl_dat),
		.led_o(led_o), .node_rst_o(node_rst_o)
	);

	io_random i_io_random (
		.clk100(clk100), .rst(rst), .preq_i(preq),
		.rand_stb_i(rand_stb), .rand_ack_o(rand_ack), .rand_dat_o(rand_dat)
	);

	io_tick_timer i_io_tick_timer (
		.clk100(clk100), .rst(rst), .tmr_irq_o(tmr_irq_o)
	);

endmodule

`default_nettype wire

//--- hw/io_tick_timer.sv
`timescale 1ns/1ps
`default_nettype none

// free-running periodic interrupt pulse
module io_tick_timer (
	input  wire   clk100,
	input  wire   rst,
	output logic  tmr_irq_o
);

	logic [io_map_pkg::TMR_CNT_W-1:0] cnt;	// 1..TMR_PERIOD

	always_ff @(posedge clk100) begin
		if (rst) begin
			cnt       <= io_map_pkg::TMR_CNT_W'(1);
			tmr_irq_o <= 1'b0;
		end else begin
			if (cnt == io_map_pkg::TMR_CNT_W'(io_map_pkg::TMR_PERIOD))
				cnt <= io_map_pkg::TMR_CNT_W'(1);	// wrap
			else
				cnt <= cnt + 1'b1;
			if (cnt == io_map_pkg::TMR_CNT_W'(io_map_pkg::TMR_ON))
				tmr_irq_o <= 1'b1;
			else if (cnt == io_map_pkg::TMR_CNT_W'(io_map_pkg::TMR_OFF))
				tmr_irq_o <= 1'b0;	// pulse width TMR_OFF - TMR_ON
		end
	end

endmodule

`default_nettype wire

//--- hw/io_random.sv
`timescale 1ns/1ps
`default_nettype none

// galois lfsr register, load reads and steps, store seeds
module io_random (
	input  wire                  clk100,
	input  wire                  rst,
	input  io_bus_pkg::io_req_t  preq_i,
	input  wire                  rand_stb_i,
	output logic                 rand_ack_o,
	output logic [31:0]          rand_dat_o
);

	logic [31:0] state;

	// one right shift, taps folded in when a 1 falls out
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		lfsr_step = (s >> 1) ^ (s[0] ? io_map_pkg::RAND_TAPS : 32'd0);
	endfunction

	always_ff @(posedge clk100) begin
		if (rst) begin
			state      <= io_map_pkg::RAND_SEED_DEFAULT;
			rand_ack_o <= 1'b0;
		end else begin
			rand_ack_o <= rand_stb_i;
			if (rand_stb_i) begin
				if (preq_i.cmd == io_bus_pkg::IO_STORE)
					// all-zero state would lock up
					state <= (preq_i.dat == 32'd0) ? io_map_pkg::RAND_SEED_DEFAULT : preq_i.dat;
				else
					state <= lfsr_step(state);	// advance after the read
			end
		end
	end

	// read value is the state before the step
	always_ff @(posedge clk100)
		rand_dat_o <= (rand_stb_i && preq_i.cmd == io_bus_pkg::IO_LOAD) ? state : 32'd0;

endmodule

`default_nettype wire

//--- hw/io_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

// led register and node reset-control register
module io_ctrl_regs (
	input  wire                                  clk100,
	input  wire                                  rst,
	input  io_bus_pkg::io_req_t                  preq_i,
	input  wire                                  leds_stb_i,
	input  wire                                  rstctl_stb_i,
	output logic                                 leds_ack_o,
	output logic [31:0]                          leds_dat_o,
	output logic                                 rstctl_ack_o,
	output logic [31:0]                          rstctl_dat_o,
	output logic [io_map_pkg::LED_W-1:0]         led_o,
	output logic [io_map_pkg::NODE_RST_W-1:0]    node_rst_o
);

	logic [io_map_pkg::RST_CNT_W-1:0] rst_cnt;	// cycles since last write
	logic is_load;
	logic is_store;

	assign is_load  = preq_i.cmd == io_bus_pkg::IO_LOAD;
	assign is_store = preq_i.cmd == io_bus_pkg::IO_STORE;

	// ----------------------------------------
	// led register
	// ----------------------------------------
	always_ff @(posedge clk100) begin
		if (rst)
			led_o <= '0;
		else if (leds_stb_i && is_store && preq_i.sel[0])
			led_o <= preq_i.dat[io_map_pkg::LED_W-1:0];	// low lane only
	end

	// ----------------------------------------
	// reset pulses
	// ----------------------------------------
	always_ff @(posedge clk100) begin
		if (rst) begin
			node_rst_o <= '0;
			rst_cnt    <= io_map_pkg::RST_CNT_W'(io_map_pkg::RST_PULSE_CYCLES);	// idle
		end else if (rstctl_stb_i && is_store && |preq_i.sel[1:0]) begin
			node_rst_o <= preq_i.dat[io_map_pkg::NODE_RST_W-1:0];
			rst_cnt    <= '0;	// restart hold time
		end else if (rst_cnt != io_map_pkg::RST_CNT_W'(io_map_pkg::RST_PULSE_CYCLES)) begin
			rst_cnt <= rst_cnt + 1'b1;
			// vector drops as the count reaches the limit
			if (rst_cnt == io_map_pkg::RST_CNT_W'(io_map_pkg::RST_PULSE_CYCLES - 1))
				node_rst_o <= '0;
		end
	end

	// acks, one cycle behind the strobes
	always_ff @(posedge clk100) begin
		if (rst) begin
			leds_ack_o   <= 1'b0;
			rstctl_ack_o <= 1'b0;
		end else begin
			leds_ack_o   <= leds_stb_i;
			rstctl_ack_o <= rstctl_stb_i;
		end
	end

	// read data, zero unless addressed by a load
	always_ff @(posedge clk100) begin
		leds_dat_o   <= (leds_stb_i && is_load) ? 32'(led_o) : 32'd0;
		rstctl_dat_o <= (rstctl_stb_i && is_load) ? 32'(node_rst_o) : 32'd0;
	end

endmodule

`default_nettype wire

//--- hw/io_bridge.sv
`timescale 1ns/1ps
`default_nettype none

// registered request stage, page decode, registered response merge
module io_bridge (
	input  wire                   clk100,
	input  wire                   rst,
	// from host port
	input  wire                   req_stb_i,
	input  io_bus_pkg::io_req_t   req_i,
	output logic                  rsp_vld_o,
	output io_bus_pkg::io_resp_t  rsp_o,
	// to peripherals
	output io_bus_pkg::io_req_t   preq_o,
	output logic                  leds_stb_o,
	output logic                  rand_stb_o,
	output logic                  rstctl_stb_o,
	input  wire                   leds_ack_i,
	input  wire                   rand_ack_i,
	input  wire                   rstctl_ack_i,
	input  wire [31:0]            leds_dat_i,
	input  wire [31:0]            rand_dat_i,
	input  wire [31:0]            rstctl_dat_i
);

	io_map_pkg::periph_sel_e psel;
	logic none_stb;	// unmapped hit, bridge stage
	logic none_ack;	// stands in for a peripheral response stage

	// page decode on the incoming address
	always_comb begin
		case (req_i.adr[31:8])
			io_map_pkg::IO_PAGE_LEDS:   psel = io_map_pkg::SEL_LEDS;
			io_map_pkg::IO_PAGE_RAND:   psel = io_map_pkg::SEL_RAND;
			io_map_pkg::IO_PAGE_RSTCTL: psel = io_map_pkg::SEL_RSTCTL;
			default:                    psel = io_map_pkg::SEL_NONE;
		endcase
	end

	// ----------------------------------------
	// request stage
	// ----------------------------------------
	always_ff @(posedge clk100) begin
		if (rst) begin
			leds_stb_o   <= 1'b0;
			rand_stb_o   <= 1'b0;
			rstctl_stb_o <= 1'b0;
			none_stb     <= 1'b0;
			none_ack     <= 1'b0;
		end else begin
			leds_stb_o   <= req_stb_i && psel == io_map_pkg::SEL_LEDS;
			rand_stb_o   <= req_stb_i && psel == io_map_pkg::SEL_RAND;
			rstctl_stb_o <= req_stb_i && psel == io_map_pkg::SEL_RSTCTL;
			none_stb     <= req_stb_i && psel == io_map_pkg::SEL_NONE;
			none_ack     <= none_stb;	// keeps err aligned with peripheral acks
		end
	end

	always_ff @(posedge clk100)
		if (req_stb_i)
			preq_o <= req_i;	// shared by all peripherals

	// ----------------------------------------
	// response merge
	// ----------------------------------------
	always_ff @(posedge clk100) begin
		if (rst)
			rsp_vld_o <= 1'b0;
		else
			rsp_vld_o <= leds_ack_i | rand_ack_i | rstctl_ack_i | none_ack;
	end

	always_ff @(posedge clk100) begin
		rsp_o.err <= none_ack;
		rsp_o.dat <= leds_dat_i | rand_dat_i | rstctl_dat_i;	// idle devices drive 0
	end

endmodule

`default_nettype wire

//--- hw/io_host_port.sv
`timescale 1ns/1ps
`default_nettype none

// four-phase req/ack front end, one bus transaction per handshake
module io_host_port (
	input  wire                   clk100,
	input  wire                   rst,
	// host side
	input  wire                   host_req_i,
	input  io_bus_pkg::io_req_t   host_bus_i,
	output logic                  host_ack_o,
	output io_bus_pkg::io_resp_t  host_resp_o,
	// bridge side
	output logic                  req_stb_o,
	output io_bus_pkg::io_req_t   req_o,
	input  wire                   rsp_vld_i,
	input  io_bus_pkg::io_resp_t  rsp_i
);

	typedef enum logic [1:0] {
		HP_IDLE,	// waiting for req, ack low
		HP_WAIT,	// strobe issued, response pending
		HP_ACK	// ack high until host drops req
	} hp_state_e;

	hp_state_e state;

	// ----------------------------------------
	// handshake fsm
	// ----------------------------------------
	always_ff @(posedge clk100) begin
		if (rst) begin
			state      <= HP_IDLE;
			req_stb_o  <= 1'b0;
			host_ack_o <= 1'b0;
		end else begin
			req_stb_o <= 1'b0;	// single cycle strobe
			case (state)
				HP_IDLE: begin
					if (host_req_i) begin
						req_stb_o <= 1'b1;
						state     <= HP_WAIT;
					end
				end
				HP_WAIT: begin
					// only one request outstanding, so any rsp_vld is ours
					if (rsp_vld_i) begin
						host_ack_o <= 1'b1;
						state      <= HP_ACK;
					end
				end
				HP_ACK: begin
					if (!host_req_i) begin	// host withdrew, end of phase 4
						host_ack_o <= 1'b0;
						state      <= HP_IDLE;
					end
				end
				default: state <= HP_IDLE;
			endcase
		end
	end

	// payload capture
	always_ff @(posedge clk100) begin
		if (state == HP_IDLE && host_req_i)
			req_o <= host_bus_i;	// host holds bus stable while req high
		if (state == HP_WAIT && rsp_vld_i)
			host_resp_o <= rsp_i;	// held for the host while ack is high
	end

endmodule

`default_nettype wire

//--- hw/io_map_pkg.sv
`default_nettype none

// address map and per-peripheral constants
package io_map_pkg;

	// which register block a request lands on
	typedef enum logic [1:0] {
		SEL_NONE   = 2'd0,	// unmapped, bridge answers err
		SEL_LEDS   = 2'd1,
		SEL_RAND   = 2'd2,
		SEL_RSTCTL = 2'd3
	} periph_sel_e;

	// ----------------------------------------
	// pages, matched against adr[31:8]
	// ----------------------------------------
	localparam logic [23:0] IO_PAGE_LEDS   = 24'hFD0FFF;
	localparam logic [23:0] IO_PAGE_RAND   = 24'hFD0FFD;
	localparam logic [23:0] IO_PAGE_RSTCTL = 24'hFD0FFC;

	// control registers
	localparam int LED_W            = 8;
	localparam int NODE_RST_W       = 16;	// one bit per node reset
	localparam int RST_PULSE_CYCLES = 64;	// hold time of a written vector
	localparam int RST_CNT_W        = 7;	// counts 0..RST_PULSE_CYCLES

	// galois lfsr
	localparam logic [31:0] RAND_TAPS         = 32'h80200003;
	localparam logic [31:0] RAND_SEED_DEFAULT = 32'h4df6704b;	// also used for seed 0

	// tick timer, count runs 1..TMR_PERIOD
	localparam int TMR_PERIOD = 1000;	// scaled down for sim
	localparam int TMR_ON     = 150;
	localparam int TMR_OFF    = 200;
	localparam int TMR_CNT_W  = 10;

endpackage

`default_nettype wire

//--- hw/io_bus_pkg.sv
`default_nettype none

// transaction types shared by host port, bridge and peripherals
package io_bus_pkg;

	// ----------------------------------------
	// widths
	// ----------------------------------------
	localparam int IO_ADR_W = 32;	// byte address
	localparam int IO_DAT_W = 32;	// one word per transfer
	localparam int IO_SEL_W = IO_DAT_W / 8;	// byte lanes

	// bus command, single bit on the wire
	typedef enum logic {
		IO_LOAD  = 1'b0,
		IO_STORE = 1'b1
	} io_cmd_e;

	// ----------------------------------------
	// request / response
	// ----------------------------------------

	// one register transaction, 69 bits
	typedef struct packed {
		io_cmd_e               cmd;	// load or store
		logic [IO_ADR_W-1:0]   adr;	// byte address
		logic [IO_SEL_W-1:0]   sel;	// lane enables
		logic [IO_DAT_W-1:0]   dat;	// store data
	} io_req_t;

	// response, 33 bits
	typedef struct packed {
		logic                  err;	// no device at address
		logic [IO_DAT_W-1:0]   dat;	// load data, zero on err
	} io_resp_t;

endpackage

`default_nettype wire
